// ==== vlog.f ====
cdma_pkg.sv
cdma_regs.sv
cdma_ctrl.sv
cdma_burst_writer.sv
circular_dma.sv
tb_circular_dma.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_circular_dma -o sim_circular_dma
sim_out=$(./obj_dir/sim_circular_dma)
echo "$sim_out"

echo "$sim_out" | grep -q "^Done: no errors$"

// ==== tb_circular_dma.sv ====
// Circular DMA testbench with register driver, stream FIFO model, AXI4 memory model and checks
module tb_circular_dma;
	localparam logic [31:0] MEM_BASE = 32'h0000_1000;
	localparam int RING_BYTES = 512;                 // 64 beats
	localparam int WAIT_LIMIT = 400;

	logic clk, arst_n, irq, fifo_rst_n, shutdown_req, shutdown_ack;
	logic [cdma_pkg::OCCUP_WIDTH-1:0] fifo_occupancy;
	logic [cdma_pkg::AXIL_ADDR_WIDTH-1:0] s_axi_awaddr, s_axi_araddr;
	logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_bvalid, s_axi_bready;
	logic s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
	logic [cdma_pkg::REG_WIDTH-1:0] s_axi_wdata, s_axi_rdata;
	logic [3:0] s_axi_wstrb;
	logic [1:0] s_axi_bresp, s_axi_rresp, m_axi_bresp;
	logic [cdma_pkg::ADDR_WIDTH-1:0] m_axi_awaddr;
	logic [cdma_pkg::LEN_WIDTH-1:0] m_axi_awlen;
	logic m_axi_awvalid, m_axi_awready, m_axi_wlast, m_axi_wvalid, m_axi_wready;
	logic m_axi_bvalid, m_axi_bready;
	logic [cdma_pkg::BEAT_WIDTH-1:0] m_axi_wdata, s_axis_s2mm_tdata;
	logic s_axis_s2mm_tlast, s_axis_s2mm_tvalid, s_axis_s2mm_tready;

	logic [31:0] lfsr = 32'h66aaf114;
	int errors = 0;
	int checked = 0;
	int beat_no = 0;
	logic [cdma_pkg::BEAT_WIDTH-1:0] stream_data[$], sent_data[$], land_data[$];
	logic stream_last[$];
	logic [cdma_pkg::ADDR_WIDTH-1:0] land_addr[$];
	logic [cdma_pkg::BEAT_WIDTH-1:0] mem[logic [cdma_pkg::ADDR_WIDTH-1:0]];
	logic aw_hs, w_hs, t_hs, b_hs, wlast_hs, b_owed, err_once, outstanding;
	logic [cdma_pkg::ADDR_WIDTH-1:0] aw_addr_hs, cur_addr;
	logic [cdma_pkg::LEN_WIDTH-1:0] burst_len;
	logic [cdma_pkg::BEAT_WIDTH-1:0] wdata_hs;
	logic [cdma_pkg::REG_WIDTH-1:0] rd;

	circular_dma u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// Helpers
	////////////////////

	// Galois LFSR, one step per bit taken
	function logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Ring offset after a number of beats
	function automatic logic [31:0] ring_offset(input int beats);
		return 32'((beats * cdma_pkg::BEAT_BYTES) % RING_BYTES);
	endfunction

	// Pending bits expected from one group of beats
	function automatic logic [2:0] ref_pending(input int prev, input int now, input logic last,
			input logic err, input logic [2:0] enable);
		logic [2:0] p;
		p = '0;
		p[cdma_pkg::IRQ_WRAP] = (now * 8) / RING_BYTES != (prev * 8) / RING_BYTES;
		p[cdma_pkg::IRQ_MSG] = last;
		p[cdma_pkg::IRQ_ERR] = err;
		return p & enable;
	endfunction

	task automatic check_beat(input logic [cdma_pkg::BEAT_WIDTH-1:0] got, exp, input string msg);
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s: got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_reg(input logic [cdma_pkg::REG_WIDTH-1:0] got, exp, input string msg);
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s: got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, exp, input string msg);
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s: got %b expected %b", $time, msg, got, exp);
		end
	endtask

	task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
		int n;
		@(negedge clk);
		s_axi_awaddr = addr;
		s_axi_wdata = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
		#1;
		check_bit(s_axi_awready && s_axi_wready, 1'b1, "register write accepted");
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!s_axi_bvalid && n < WAIT_LIMIT);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		if (!s_axi_bvalid) begin
			errors++;
			$display("Register write to %h got no response in time", addr);
		end else begin
			check_bit(n == 1, 1'b1, "write response one cycle after accept");
			check_bit(s_axi_bresp == cdma_pkg::RESP_OKAY, 1'b1, "write response OKAY");
		end
		@(negedge clk);                             // bready is held high
	endtask

	task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
		int n;
		@(negedge clk);
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		#1;
		check_bit(s_axi_arready, 1'b1, "register read accepted");
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!s_axi_rvalid && n < WAIT_LIMIT);
		s_axi_arvalid = 1'b0;
		if (!s_axi_rvalid) begin
			errors++;
			$display("Register read of %h returned no data in time", addr);
		end else begin
			check_bit(n == 1, 1'b1, "read data one cycle after accept");
			check_bit(s_axi_rresp == cdma_pkg::RESP_OKAY, 1'b1, "read response OKAY");
		end
		data = s_axi_rdata;
		s_axi_rready = 1'b1;
		@(negedge clk);
		s_axi_rready = 1'b0;
	endtask

	task automatic push_beats(input int n, input logic last_on_final);
		logic [63:0] d;
		for (int i = 0; i < n; i++) begin
			d = {rand_bits(32), rand_bits(32)};
			stream_data.push_back(d);
			sent_data.push_back(d);
			stream_last.push_back(last_on_final && i == n - 1);
		end
	endtask

	// Engine idle with an empty FIFO
	task automatic wait_idle();
		logic [31:0] s;
		int n;
		n = 0;
		do begin
			read_reg(cdma_pkg::REG_STATUS, s);
			n++;
		end while (s != 32'h2 && n < WAIT_LIMIT);
		if (s != 32'h2) begin
			errors++;
			$display("Engine did not go idle in time");
		end
	endtask

	// Newest beat expected in each ring slot
	task automatic check_ring_image();
		int first;
		first = sent_data.size() - RING_BYTES / cdma_pkg::BEAT_BYTES;
		if (first < 0) begin
			first = 0;
		end
		for (int i = first; i < sent_data.size(); i++) begin
			check_beat(mem[MEM_BASE + ring_offset(i)], sent_data[i], "ring image");
		end
	endtask

	////////////////////
	// Stream and memory models
	////////////////////

	initial begin
		forever begin
			@(negedge clk);
			if (t_hs) begin
				void'(stream_data.pop_front());
				void'(stream_last.pop_front());
			end
			if (w_hs) begin
				check_bit(wlast_hs, beat_no == int'(burst_len), "wlast on final beat");
				beat_no++;
				mem[cur_addr] = wdata_hs;
				land_addr.push_back(cur_addr);
				land_data.push_back(wdata_hs);
				cur_addr += cdma_pkg::BEAT_BYTES;
				b_owed = b_owed | wlast_hs;
			end
			if (aw_hs) begin
				cur_addr = aw_addr_hs;
				burst_len = m_axi_awlen;
				beat_no = 0;
				outstanding = 1'b1;
				check_bit(m_axi_awlen < 8'd16, 1'b1, "burst at most 16 beats");
			end
			if (b_hs) begin
				m_axi_bvalid = 1'b0;
				outstanding = 1'b0;
			end
			m_axi_awready = |rand_bits(2);
			m_axi_wready = |rand_bits(2);
			if (b_owed && !m_axi_bvalid && rand_bits(1) == 1) begin
				m_axi_bvalid = 1'b1;
				m_axi_bresp = err_once ? 2'b10 : 2'b00;   // SLVERR on demand
				err_once = 1'b0;
				b_owed = 1'b0;
			end
			fifo_occupancy = cdma_pkg::OCCUP_WIDTH'(stream_data.size());
			s_axis_s2mm_tvalid = stream_data.size() > 0;
			s_axis_s2mm_tdata = stream_data.size() > 0 ? stream_data[0] : '0;
			s_axis_s2mm_tlast = stream_last.size() > 0 ? stream_last[0] : 1'b0;
			#1;
			aw_hs = m_axi_awvalid && m_axi_awready;
			aw_addr_hs = m_axi_awaddr;
			w_hs = m_axi_wvalid && m_axi_wready;
			t_hs = s_axis_s2mm_tvalid && s_axis_s2mm_tready;
			wdata_hs = m_axi_wdata;
			wlast_hs = m_axi_wlast;
			b_hs = m_axi_bvalid && m_axi_bready;
			check_bit(t_hs, w_hs, "stream beat taken with its W beat");
		end
	end

	// Compare each landed write with the beat order and the ring layout
	initial begin
		forever begin
			@(posedge clk);
			while (land_addr.size() > 0) begin
				if (checked >= sent_data.size()) begin
					errors++;
					$display("Memory write seen with no beat left to send");
					void'(land_addr.pop_front());
					void'(land_data.pop_front());
				end else begin
					check_reg(land_addr.pop_front(), MEM_BASE + ring_offset(checked), "write addr");
					check_beat(land_data.pop_front(), sent_data[checked], "write data");
					checked++;
				end
			end
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		arst_n = 1'b0;
		shutdown_req = 1'b0;
		fifo_occupancy = '0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = 4'hF;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b1;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		m_axi_awready = 1'b0;
		m_axi_wready = 1'b0;
		m_axi_bresp = 2'b00;
		m_axi_bvalid = 1'b0;
		s_axis_s2mm_tdata = '0;
		s_axis_s2mm_tlast = 1'b0;
		s_axis_s2mm_tvalid = 1'b0;
		{aw_hs, w_hs, t_hs, b_hs, wlast_hs, b_owed, err_once, outstanding} = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_bit(|{m_axi_awvalid, m_axi_wvalid, m_axi_bready, s_axis_s2mm_tready,
			s_axi_bvalid, s_axi_rvalid, irq, shutdown_ack}, 1'b0, "outputs low in reset");
		check_bit(fifo_rst_n, 1'b0, "FIFO reset during arst_n");
		arst_n = 1'b1;
		#1;
		check_bit(fifo_rst_n, 1'b1, "FIFO out of reset");

		// Plain traffic
		write_reg(cdma_pkg::REG_BASE, MEM_BASE);
		write_reg(cdma_pkg::REG_SIZE, RING_BYTES);
		write_reg(cdma_pkg::REG_TIMEOUT, 32'd20);
		write_reg(cdma_pkg::REG_CTRL, 32'h19);          // enable, WRAP and MSG irqs
		push_beats(40, 1'b0);
		wait_idle();
		check_reg(32'(checked), 32'd40, "beats written");
		read_reg(cdma_pkg::REG_WRITTEN, rd);
		check_reg(rd, ring_offset(40), "written offset");

		// Wrap around the ring
		push_beats(40, 1'b0);
		wait_idle();
		read_reg(cdma_pkg::REG_WRITTEN, rd);
		check_reg(rd, ring_offset(80), "written offset after wrap");
		check_bit(irq, 1'b1, "irq on wrap");
		read_reg(cdma_pkg::REG_IRQ, rd);
		check_reg(rd, 32'(ref_pending(40, 80, 1'b0, 1'b0, 3'b011)), "wrap pending");
		write_reg(cdma_pkg::REG_IRQ, 32'h1);
		read_reg(cdma_pkg::REG_IRQ, rd);
		check_reg(rd, 32'h0, "wrap cleared");
		check_bit(irq, 1'b0, "irq after clear");

		// Partial burst ending a message
		push_beats(5, 1'b1);
		wait_idle();
		read_reg(cdma_pkg::REG_MSG_END, rd);
		check_reg(rd, ring_offset(85), "message end");
		read_reg(cdma_pkg::REG_IRQ, rd);
		check_reg(rd, 32'(ref_pending(80, 85, 1'b1, 1'b0, 3'b011)), "message pending");
		write_reg(cdma_pkg::REG_IRQ, 32'h7);

		// Bus error with only the error source enabled
		write_reg(cdma_pkg::REG_CTRL, 32'h21);
		err_once = 1'b1;
		push_beats(16, 1'b1);
		wait_idle();
		read_reg(cdma_pkg::REG_IRQ, rd);
		check_reg(rd, 32'(ref_pending(85, 101, 1'b1, 1'b1, 3'b100)), "error pending");

		// Shutdown during traffic with the error still pending
		write_reg(cdma_pkg::REG_CTRL, 32'h39);
		push_beats(48, 1'b0);
		for (int n = 0; n < WAIT_LIMIT && !outstanding; n++) begin
			@(negedge clk);
			#2;
		end
		if (!outstanding) begin
			errors++;
			$display("No burst started before shutdown");
		end
		check_bit(irq, 1'b1, "irq pending before shutdown");
		@(negedge clk);
		shutdown_req = 1'b1;
		for (int n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge clk);
			#2;
			check_bit(irq, 1'b0, "irq masked in shutdown");
			if (shutdown_ack) begin
				check_bit(outstanding || m_axi_awvalid || m_axi_bready, 1'b0, "idle on ack");
				break;
			end
		end
		if (!shutdown_ack) begin
			errors++;
			$display("Shutdown was not acknowledged in time");
		end
		repeat (10) begin
			@(negedge clk);
			check_bit(shutdown_ack && !m_axi_awvalid && !irq, 1'b1, "quiet while shut down");
		end
		shutdown_req = 1'b0;
		wait_idle();
		check_reg(32'(checked), 32'(sent_data.size()), "all beats written");
		check_ring_image();
		write_reg(cdma_pkg::REG_CTRL, 32'h2);           // srst
		@(negedge clk);
		check_bit(fifo_rst_n, 1'b0, "FIFO reset on srst");

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== circular_dma.sv ====
// Circular DMA top writing an AXI4-Stream into a memory ring buffer over AXI4
module circular_dma (
	input logic clk,
	input logic arst_n,
	input logic [cdma_pkg::OCCUP_WIDTH-1:0] fifo_occupancy,
	output logic irq,
	output logic fifo_rst_n,
	input logic shutdown_req,
	output logic shutdown_ack,

	input logic [cdma_pkg::AXIL_ADDR_WIDTH-1:0] s_axi_awaddr,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input logic [cdma_pkg::REG_WIDTH-1:0] s_axi_wdata,
	input logic [cdma_pkg::REG_WIDTH/8-1:0] s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic [cdma_pkg::AXIL_ADDR_WIDTH-1:0] s_axi_araddr,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [cdma_pkg::REG_WIDTH-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,

	output logic [cdma_pkg::ADDR_WIDTH-1:0] m_axi_awaddr,
	output logic [cdma_pkg::LEN_WIDTH-1:0] m_axi_awlen,
	output logic m_axi_awvalid,
	input logic m_axi_awready,
	output logic [cdma_pkg::BEAT_WIDTH-1:0] m_axi_wdata,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,
	input logic [1:0] m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready,

	input logic [cdma_pkg::BEAT_WIDTH-1:0] s_axis_s2mm_tdata,
	input logic s_axis_s2mm_tlast,
	input logic s_axis_s2mm_tvalid,
	output logic s_axis_s2mm_tready
);
	cdma_pkg::cdma_cfg_t cfg;
	cdma_pkg::cdma_stat_t stat;
	cdma_pkg::cdma_burst_t cmd;
	logic srst, cmd_valid, cmd_ready, done, resp_err, saw_last;
	logic [cdma_pkg::IRQ_COUNT-1:0] irq_clear;
	logic [cdma_pkg::LEN_WIDTH:0] beats_done;
	logic [cdma_pkg::LEN_WIDTH-1:0] last_beat_idx;

	////////////////////
	// Blocks
	////////////////////

	cdma_regs u_regs (.*);                  // Register slave
	cdma_ctrl u_ctrl (.*);                  // Burst scheduling and interrupts
	cdma_burst_writer u_writer (.*);        // AXI4 write datapath

	// Interrupt is masked while the system is quiescing
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			irq <= 1'b0;
		end else begin
			irq <= (|stat.irq_pending) && !shutdown_req;
		end
	end

	assign fifo_rst_n = arst_n & ~srst;     // External FIFO held in reset by srst

endmodule

// ==== cdma_burst_writer.sv ====
// AXI4 write master moving one stream burst through the AW, W and B phases
module cdma_burst_writer (
	input logic clk,
	input logic arst_n,
	input cdma_pkg::cdma_burst_t cmd,
	input logic cmd_valid,
	output logic cmd_ready,
	output logic done,
	output logic resp_err,
	output logic saw_last,
	output logic [cdma_pkg::LEN_WIDTH:0] beats_done,
	output logic [cdma_pkg::LEN_WIDTH-1:0] last_beat_idx,

	output logic [cdma_pkg::ADDR_WIDTH-1:0] m_axi_awaddr,
	output logic [cdma_pkg::LEN_WIDTH-1:0] m_axi_awlen,
	output logic m_axi_awvalid,
	input logic m_axi_awready,
	output logic [cdma_pkg::BEAT_WIDTH-1:0] m_axi_wdata,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,
	input logic [1:0] m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready,

	input logic [cdma_pkg::BEAT_WIDTH-1:0] s_axis_s2mm_tdata,
	input logic s_axis_s2mm_tlast,
	input logic s_axis_s2mm_tvalid,
	output logic s_axis_s2mm_tready
);
	typedef enum logic [1:0] {ST_IDLE, ST_AW, ST_W, ST_B} state_t;

	state_t state;
	cdma_pkg::cdma_burst_t cmd_q;
	logic [cdma_pkg::LEN_WIDTH-1:0] beat_cnt;
	logic w_hs;

	assign cmd_ready = state == ST_IDLE;
	assign m_axi_awvalid = state == ST_AW;
	assign m_axi_awaddr = cmd_q.addr;
	assign m_axi_awlen = cmd_q.len;
	assign m_axi_wvalid = (state == ST_W) && s_axis_s2mm_tvalid;   // Stream beat passes through
	assign s_axis_s2mm_tready = (state == ST_W) && m_axi_wready;
	assign m_axi_wdata = s_axis_s2mm_tdata;
	assign m_axi_wlast = beat_cnt == cmd_q.len;
	assign m_axi_bready = state == ST_B;
	assign w_hs = m_axi_wvalid && m_axi_wready;
	assign done = m_axi_bvalid && m_axi_bready;
	assign resp_err = m_axi_bresp != cdma_pkg::RESP_OKAY;
	assign beats_done = {1'b0, cmd_q.len} + 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			saw_last <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cmd_valid) begin
						saw_last <= 1'b0;               // Fresh burst
						state <= ST_AW;
					end
				end
				ST_AW: begin
					if (m_axi_awready) begin
						state <= ST_W;
					end
				end
				ST_W: begin
					if (w_hs) begin
						if (s_axis_s2mm_tlast) begin
							saw_last <= 1'b1;
						end
						if (m_axi_wlast) begin
							state <= ST_B;
						end
					end
				end
				ST_B: begin
					if (m_axi_bvalid) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_ready) begin
			cmd_q <= cmd;
			beat_cnt <= '0;
		end else if (w_hs) begin
			beat_cnt <= beat_cnt + 1'b1;
			if (s_axis_s2mm_tlast) begin
				last_beat_idx <= beat_cnt;          // Last tlast seen wins
			end
		end
	end

	// B phase opens right after beat awlen and never earlier
	assert property (@(posedge clk) disable iff (!arst_n)
		w_hs |=> m_axi_bready == $past(beat_cnt == m_axi_awlen));

endmodule

// ==== cdma_ctrl.sv ====
// DMA control FSM choosing burst length, wrapping the ring offset and raising interrupts
module cdma_ctrl (
	input logic clk,
	input logic arst_n,
	input cdma_pkg::cdma_cfg_t cfg,
	input logic [cdma_pkg::IRQ_COUNT-1:0] irq_clear,
	input logic [cdma_pkg::OCCUP_WIDTH-1:0] fifo_occupancy,
	input logic shutdown_req,
	output logic shutdown_ack,
	output cdma_pkg::cdma_stat_t stat,
	output cdma_pkg::cdma_burst_t cmd,
	output logic cmd_valid,
	input logic cmd_ready,
	input logic done,
	input logic resp_err,
	input logic saw_last,
	input logic [cdma_pkg::LEN_WIDTH:0] beats_done,
	input logic [cdma_pkg::LEN_WIDTH-1:0] last_beat_idx
);
	typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT} state_t;

	state_t state;
	logic [cdma_pkg::ADDR_WIDTH-1:0] offset_q, msg_end_q, next_off, msg_end;
	logic [cdma_pkg::ADDR_WIDTH-1:0] occ, beats_left, burst_beats;
	logic [cdma_pkg::REG_WIDTH-1:0] idle_cnt;
	logic [cdma_pkg::IRQ_COUNT-1:0] pending_q, irq_set;
	logic full_burst, timed_out, go, wrap;

	////////////////////
	// Burst decision
	////////////////////

	always_comb begin
		occ = cdma_pkg::ADDR_WIDTH'(fifo_occupancy);
		beats_left = (cfg.mem_size - offset_q) >> cdma_pkg::BEAT_SHIFT;  // Up to buffer end
		burst_beats = occ;
		if (burst_beats > cdma_pkg::MAX_BURST) begin
			burst_beats = cdma_pkg::MAX_BURST;
		end
		if (burst_beats > beats_left) begin
			burst_beats = beats_left;
		end
		full_burst = occ >= cdma_pkg::MAX_BURST;
		timed_out = (occ != '0) && (cfg.flush_fifo || idle_cnt >= cfg.timeout);
		go = cfg.enable && !shutdown_req && (beats_left != '0) && (full_burst || timed_out);
	end

	// Completion bookkeeping
	always_comb begin
		next_off = offset_q + (cdma_pkg::ADDR_WIDTH'(beats_done) << cdma_pkg::BEAT_SHIFT);
		wrap = next_off >= cfg.mem_size;
		msg_end = offset_q
			+ ((cdma_pkg::ADDR_WIDTH'(last_beat_idx) + 1) << cdma_pkg::BEAT_SHIFT);
		if (msg_end >= cfg.mem_size) begin
			msg_end = '0;                           // Message ended on the last slot
		end
		irq_set = '0;
		irq_set[cdma_pkg::IRQ_WRAP] = done && wrap;
		irq_set[cdma_pkg::IRQ_MSG] = done && saw_last;
		irq_set[cdma_pkg::IRQ_ERR] = done && resp_err;
		irq_set = irq_set & cfg.irq_enable;       // Disabled sources never pend
	end

	////////////////////
	// FSM
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			offset_q <= '0;
			msg_end_q <= '0;
			idle_cnt <= '0;
			pending_q <= '0;
			cmd_valid <= 1'b0;
			shutdown_ack <= 1'b0;
		end else begin
			pending_q <= (pending_q & ~irq_clear) | irq_set;
			shutdown_ack <= shutdown_req && (state == ST_IDLE);  // Nothing in flight
			case (state)
				ST_IDLE: begin
					if (go) begin
						cmd_valid <= 1'b1;
						idle_cnt <= '0;
						state <= ST_ISSUE;
					end else if (occ == '0) begin
						idle_cnt <= '0;
					end else if (idle_cnt != '1) begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				ST_ISSUE: begin
					if (cmd_ready) begin
						cmd_valid <= 1'b0;
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (done) begin
						offset_q <= wrap ? '0 : next_off;
						if (saw_last) begin
							msg_end_q <= msg_end;
						end
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && go) begin
			cmd.addr <= cfg.mem_base + offset_q;
			cmd.len <= cdma_pkg::LEN_WIDTH'(burst_beats - 1);
		end
	end

	assign stat.irq_pending = pending_q;
	assign stat.busy = state != ST_IDLE;
	assign stat.fifo_empty = fifo_occupancy == '0;
	assign stat.bytes_written = offset_q;
	assign stat.last_msg_end = msg_end_q;

	// Burst stays inside the ring
	assert property (@(posedge clk) disable iff (!arst_n)
		cmd_valid |-> (cmd.addr - cfg.mem_base)
			+ ((cdma_pkg::ADDR_WIDTH'(cmd.len) + 1) << cdma_pkg::BEAT_SHIFT) <= cfg.mem_size);

	assert property (@(posedge clk) disable iff (!arst_n)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

// ==== cdma_regs.sv ====
// AXI4-Lite register slave holding the DMA configuration, status readback and interrupt clear
module cdma_regs (
	input logic clk,
	input logic arst_n,

	input logic [cdma_pkg::AXIL_ADDR_WIDTH-1:0] s_axi_awaddr,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input logic [cdma_pkg::REG_WIDTH-1:0] s_axi_wdata,
	input logic [cdma_pkg::REG_WIDTH/8-1:0] s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic [cdma_pkg::AXIL_ADDR_WIDTH-1:0] s_axi_araddr,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [cdma_pkg::REG_WIDTH-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,

	output cdma_pkg::cdma_cfg_t cfg,
	output logic srst,
	output logic [cdma_pkg::IRQ_COUNT-1:0] irq_clear,
	input cdma_pkg::cdma_stat_t stat
);
	logic wr_en, rd_en;
	logic [cdma_pkg::REG_WIDTH-1:0] wmask, rd_mux;
	logic [cdma_pkg::REG_WIDTH-1:0] base_q, size_q, timeout_q;
	cdma_pkg::cdma_reg_word_u ctrl_q, wr_word, irq_word, irq_rd;

	// Byte-lane merge of a write into the current register value
	function automatic logic [cdma_pkg::REG_WIDTH-1:0] merge(
		input logic [cdma_pkg::REG_WIDTH-1:0] cur
	);
		merge = (cur & ~wmask) | (s_axi_wdata & wmask);
	endfunction

	assign wr_en = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;  // AW and W taken together
	assign s_axi_awready = wr_en;
	assign s_axi_wready = wr_en;
	assign s_axi_bresp = cdma_pkg::RESP_OKAY;
	assign s_axi_arready = ~s_axi_rvalid;
	assign rd_en = s_axi_arvalid & s_axi_arready;
	assign s_axi_rresp = cdma_pkg::RESP_OKAY;

	always_comb begin
		for (int i = 0; i < cdma_pkg::REG_WIDTH / 8; i++) begin
			wmask[8*i +: 8] = {8{s_axi_wstrb[i]}};
		end
		wr_word = merge(ctrl_q);
		wr_word.ctrl.rsvd = '0;                 // Unused bits read as zero
		irq_word = s_axi_wdata & wmask;
	end

	////////////////////
	// Write path
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_q <= '0;
			base_q <= '0;
			size_q <= '0;
			timeout_q <= '0;
			irq_clear <= '0;
			s_axi_bvalid <= 1'b0;
		end else begin
			irq_clear <= '0;                    // One-cycle pulse
			if (s_axi_bvalid && s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
			if (wr_en) begin
				s_axi_bvalid <= 1'b1;
				case (s_axi_awaddr)
					cdma_pkg::REG_CTRL: ctrl_q <= wr_word;
					cdma_pkg::REG_IRQ: irq_clear <= irq_word.irq.pending;
					cdma_pkg::REG_BASE: base_q <= merge(base_q);
					cdma_pkg::REG_SIZE: size_q <= merge(size_q);
					cdma_pkg::REG_TIMEOUT: timeout_q <= merge(timeout_q);
					default: ;                      // Read-only or unmapped
				endcase
			end
		end
	end

	////////////////////
	// Read path
	////////////////////

	always_comb begin
		irq_rd = '0;
		irq_rd.irq.pending = stat.irq_pending;
		case (s_axi_araddr)
			cdma_pkg::REG_CTRL: rd_mux = ctrl_q;
			cdma_pkg::REG_IRQ: rd_mux = irq_rd;
			cdma_pkg::REG_BASE: rd_mux = base_q;
			cdma_pkg::REG_SIZE: rd_mux = size_q;
			cdma_pkg::REG_WRITTEN: rd_mux = stat.bytes_written;
			cdma_pkg::REG_MSG_END: rd_mux = stat.last_msg_end;
			cdma_pkg::REG_TIMEOUT: rd_mux = timeout_q;
			cdma_pkg::REG_STATUS: rd_mux = cdma_pkg::REG_WIDTH'({stat.fifo_empty, stat.busy});
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s_axi_rvalid <= 1'b0;
		end else if (rd_en) begin
			s_axi_rvalid <= 1'b1;
		end else if (s_axi_rready) begin
			s_axi_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			s_axi_rdata <= rd_mux;                // Held until rready
		end
	end

	assign cfg.enable = ctrl_q.ctrl.enable;
	assign cfg.flush_fifo = ctrl_q.ctrl.flush_fifo;
	assign cfg.irq_enable = ctrl_q.ctrl.irq_enable;
	assign cfg.mem_base = base_q;
	assign cfg.mem_size = size_q;
	assign cfg.timeout = timeout_q;
	assign srst = ctrl_q.ctrl.srst;

	// A write response only follows an accepted write
	assert property (@(posedge clk) disable iff (!arst_n)
		$rose(s_axi_bvalid) |-> $past(s_axi_awvalid && s_axi_awready && s_axi_wvalid));

endmodule

// ==== cdma_pkg.sv ====
// Circular DMA shared widths, register map and the types passed between its blocks
package cdma_pkg;

	////////////////////
	// Widths
	////////////////////

	localparam int REG_WIDTH = 32;          // AXI4-Lite data
	localparam int AXIL_ADDR_WIDTH = 12;    // AXI4-Lite address
	localparam int ADDR_WIDTH = 32;         // Memory address
	localparam int BEAT_WIDTH = 64;         // Stream and memory data
	localparam int BEAT_BYTES = BEAT_WIDTH / 8;
	localparam int BEAT_SHIFT = $clog2(BEAT_BYTES);
	localparam int MAX_BURST = 16;          // Beats
	localparam int OCCUP_WIDTH = 16;
	localparam int LEN_WIDTH = 8;           // AXI4 awlen
	localparam int IRQ_COUNT = 3;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	////////////////////
	// Register map
	////////////////////

	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL = 12'h000;
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_IRQ = 12'h004;
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_BASE = 12'h008;
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_SIZE = 12'h00C;
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_WRITTEN = 12'h010;
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_MSG_END = 12'h014;
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_TIMEOUT = 12'h018;
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_STATUS = 12'h01C;

	// Interrupt source bit positions
	localparam int IRQ_WRAP = 0;
	localparam int IRQ_MSG = 1;
	localparam int IRQ_ERR = 2;

	// One register word, seen as REG_CTRL or as REG_IRQ
	typedef union packed {
		struct packed {
			logic [REG_WIDTH-7:0] rsvd;
			logic [IRQ_COUNT-1:0] irq_enable;
			logic flush_fifo;
			logic srst;
			logic enable;
		} ctrl;
		struct packed {
			logic [REG_WIDTH-4:0] rsvd;
			logic [IRQ_COUNT-1:0] pending;  // Status on read, clear on write
		} irq;
	} cdma_reg_word_u;

	typedef struct packed {
		logic enable;
		logic flush_fifo;
		logic [IRQ_COUNT-1:0] irq_enable;
		logic [ADDR_WIDTH-1:0] mem_base;
		logic [REG_WIDTH-1:0] mem_size;    // Bytes
		logic [REG_WIDTH-1:0] timeout;     // Idle cycles before a partial burst
	} cdma_cfg_t;

	typedef struct packed {
		logic [IRQ_COUNT-1:0] irq_pending;
		logic busy;
		logic fifo_empty;
		logic [REG_WIDTH-1:0] bytes_written;
		logic [REG_WIDTH-1:0] last_msg_end;
	} cdma_stat_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0] len;         // Beats minus one
	} cdma_burst_t;

endpackage
